// File: source/conv_acc_if.sv
// accumulator result of one datapath; valid and last are strobes qualified by that lane's enable
`default_nettype none

interface conv_acc_if import conv_pkg::*; ();

    logic valid;  // sum register holds a fresh word
    logic last;   // word closes a group
    logic is_1x1; // mode travels with the data
    sum_t data;   // running or finished sum

    // driven by the owning datapath
    modport acc (
        output valid, last, is_1x1, data
    );

    // snake control, output shifter, right neighbour
    modport sink (
        input valid, last, is_1x1, data
    );

endinterface

`default_nettype wire

// File: source/conv_datapath.sv
// one column: multiplier, carry mux (lanes above 0), accumulator; sums wrap at SUM_W bits
`default_nettype none

module conv_datapath import conv_pkg::*; #(
    parameter logic [KW_BITS-1:0] LANE = '0 // datapath index, below KERNEL_W
) (
    input  logic    aclk,
    input  logic    rst,
    input  logic    clken_mul,
    input  logic    clken_acc,
    input  logic    in_valid,
    input  logic    in_last,
    input  logic    in_is_1x1,
    input  pix_t    pixel,
    input  pix_t    weight,
    input  logic    sel,        // take the left neighbour's sum
    conv_acc_if.sink carry,
    output logic    mul_valid,
    output logic    mul_last,
    output logic    mul_is_1x1,
    conv_acc_if.acc acc
);

    localparam int AD = ACC_DELAY - 1; // input stages ahead of the sum register

    logic [MUL_DELAY-1:0] mv_q, ml_q, mo_q;
    sum_t                 md_q [MUL_DELAY];
    logic                 ax_valid, ax_last, ax_is_1x1; // accumulator input
    sum_t                 ax_data;
    logic [AD-1:0]        av_q, al_q, ao_q;
    sum_t                 ad_q [AD];
    logic                 fresh;                         // next word starts a group

    always_ff @(posedge aclk) begin
        if (rst) begin
            mv_q <= '0;
            ml_q <= '0;
            mo_q <= '0;
        end else if (clken_mul) begin
            for (int k = MUL_DELAY - 1; k > 0; k--) begin
                mv_q[k] <= mv_q[k-1];
                ml_q[k] <= ml_q[k-1];
                mo_q[k] <= mo_q[k-1];
            end
            mv_q[0] <= in_valid;
            ml_q[0] <= in_last;
            mo_q[0] <= in_is_1x1;
        end
    end

    always_ff @(posedge aclk) begin
        if (clken_mul) begin
            for (int k = MUL_DELAY - 1; k > 0; k--) begin
                md_q[k] <= md_q[k-1];
            end
            md_q[0] <= sum_t'(pixel) * sum_t'(weight); // full signed product
        end
    end

    assign mul_valid  = mv_q[MUL_DELAY-1];
    assign mul_last   = ml_q[MUL_DELAY-1];
    assign mul_is_1x1 = mo_q[MUL_DELAY-1];

    if (LANE == 0) begin : g_direct
        // leftmost lane, product straight in
        assign ax_valid  = mul_valid & clken_mul;
        assign ax_last   = mul_last;
        assign ax_is_1x1 = mul_is_1x1;
        assign ax_data   = md_q[MUL_DELAY-1];
    end else begin : g_mux
        // registered mux, one extra stage that absorbs the hand-over clock
        always_ff @(posedge aclk) begin
            if (rst) begin
                ax_valid  <= 1'b0;
                ax_last   <= 1'b0;
                ax_is_1x1 <= 1'b0;
            end else if (clken_acc) begin
                ax_valid  <= sel ? (carry.valid & carry.last) : mul_valid;
                ax_last   <= sel ? 1'b0 : mul_last; // carried sum never closes a group
                ax_is_1x1 <= sel ? carry.is_1x1 : mul_is_1x1;
            end
        end

        always_ff @(posedge aclk) begin
            if (clken_acc) begin
                ax_data <= sel ? carry.data : md_q[MUL_DELAY-1];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            av_q       <= '0;
            al_q       <= '0;
            ao_q       <= '0;
            fresh      <= 1'b1;
            acc.valid  <= 1'b0;
            acc.last   <= 1'b0;
            acc.is_1x1 <= 1'b0;
        end else if (clken_acc) begin
            for (int k = AD - 1; k > 0; k--) begin
                av_q[k] <= av_q[k-1];
                al_q[k] <= al_q[k-1];
                ao_q[k] <= ao_q[k-1];
            end
            av_q[0]    <= ax_valid;
            al_q[0]    <= ax_last;
            ao_q[0]    <= ax_is_1x1;
            acc.valid  <= av_q[AD-1];
            acc.last   <= av_q[AD-1] & al_q[AD-1];
            acc.is_1x1 <= ao_q[AD-1];
            if (av_q[AD-1]) begin
                fresh <= al_q[AD-1]; // restart after a last
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (clken_acc) begin
            for (int k = AD - 1; k > 0; k--) begin
                ad_q[k] <= ad_q[k-1];
            end
            ad_q[0] <= ax_data;
            if (av_q[AD-1]) begin
                acc.data <= (fresh ? sum_t'(0) : acc.data) + ad_q[AD-1];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/conv_pkg.sv
// shared widths and delays; kernel width fixed at 3, sums wrap modulo 2^SUM_W, STEP follows ACC_DELAY
`default_nettype none

package conv_pkg;

    // datapath count, one per kernel column
    localparam int KERNEL_W  = 3;
    localparam int KW_BITS   = $clog2(KERNEL_W); // datapath index width

    // operand and sum widths, two's complement
    localparam int PIX_W     = 8;
    localparam int SUM_W     = 24;

    // pipeline depths in enabled clocks
    localparam int MUL_DELAY = 2;
    localparam int ACC_DELAY = 2;

    // skew between neighbouring datapaths
    // one less than ACC_DELAY so the left sum lands one beat after the last product
    localparam int STEP      = ACC_DELAY - 1;

    typedef logic signed [PIX_W-1:0] pix_t;
    typedef logic signed [SUM_W-1:0] sum_t;

    // one bit per datapath
    typedef logic [KERNEL_W-1:0] lane_mask_t;

endpackage

`default_nettype wire

// File: source/conv_unit.sv
// top level; m_ready is the clock enable, s_valid must stay high through a run, CIN >= 4
`default_nettype none

module conv_unit import conv_pkg::*; (
    input  logic aclk,
    input  logic rst,
    input  logic s_valid,
    input  logic s_last,
    input  logic s_is_1x1,
    input  pix_t s_pixels  [KERNEL_W],
    input  pix_t s_weights [KERNEL_W],
    output logic s_ready,
    input  logic m_ready,
    output logic m_valid,
    output logic m_last,
    output sum_t m_data
);

    lane_mask_t lane_valid, lane_last, lane_is_1x1;
    pix_t       lane_pixel  [KERNEL_W];
    pix_t       lane_weight [KERNEL_W];
    lane_mask_t mul_valid, mul_last, mul_is_1x1;
    lane_mask_t mux_sel, clken_acc;
    logic       clken_mul;

    conv_acc_if acc_bus [KERNEL_W] ();

    assign s_ready = clken_mul; // drops during each hand-over

    step_buffer i_step (
        .aclk(aclk), .rst(rst), .en(clken_mul),
        .in_valid(s_valid), .in_last(s_last), .in_is_1x1(s_is_1x1),
        .in_pixels(s_pixels), .in_weights(s_weights),
        .lane_valid(lane_valid), .lane_last(lane_last), .lane_is_1x1(lane_is_1x1),
        .lane_pixel(lane_pixel), .lane_weight(lane_weight)
    );

    snake_control i_snake (
        .aclk(aclk), .rst(rst), .m_ready(m_ready),
        .mul_last(mul_last), .mul_valid(mul_valid), .mul_is_1x1(mul_is_1x1),
        .acc(acc_bus), .mux_sel(mux_sel), .clken_mul(clken_mul), .clken_acc(clken_acc)
    );

    for (genvar i = 0; i < KERNEL_W; i++) begin : g_dp
        conv_datapath #(.LANE(KW_BITS'(i))) i_dp (
            .aclk(aclk), .rst(rst), .clken_mul(clken_mul), .clken_acc(clken_acc[i]),
            .in_valid(lane_valid[i]), .in_last(lane_last[i]), .in_is_1x1(lane_is_1x1[i]),
            .pixel(lane_pixel[i]), .weight(lane_weight[i]), .sel(mux_sel[i]),
            .carry(acc_bus[(i == 0) ? 0 : i - 1]), // lane 0 ignores its carry
            .mul_valid(mul_valid[i]), .mul_last(mul_last[i]), .mul_is_1x1(mul_is_1x1[i]),
            .acc(acc_bus[i])
        );
    end

    output_shifter i_out (
        .aclk(aclk), .rst(rst), .m_ready(m_ready), .acc(acc_bus),
        .m_valid(m_valid), .m_last(m_last), .m_data(m_data)
    );

endmodule

`default_nettype wire

// File: source/output_shifter.sv
// one-shot result strobes and right-to-left shift chain; a result colliding with a shift is lost
`default_nettype none

module output_shifter import conv_pkg::*; (
    input  logic     aclk,
    input  logic     rst,
    input  logic     m_ready,       // shifts only on downstream ready
    conv_acc_if.sink acc [KERNEL_W],
    output logic     m_valid,
    output logic     m_last,
    output sum_t     m_data
);

    lane_mask_t hit;               // finished sum visible
    lane_mask_t hit_q;             // previous enabled clock
    lane_mask_t res;               // first clock of a finished sum
    lane_mask_t nv;                // next stage valid
    lane_mask_t sv_q;              // stage holds a word
    sum_t       nd   [KERNEL_W];
    sum_t       sd_q [KERNEL_W];

    for (genvar i = 0; i < KERNEL_W; i++) begin : g_stage
        // n x m: only the rightmost lane carries a full result
        assign hit[i] = acc[i].valid & acc[i].last & ((i == KERNEL_W - 1) | acc[i].is_1x1);
        assign res[i] = hit[i] & ~hit_q[i]; // held sums during a freeze count once

        if (i < KERNEL_W - 1) begin : g_chain
            assign nv[i] = sv_q[i+1] | res[i];
            assign nd[i] = sv_q[i+1] ? sd_q[i+1] : acc[i].data; // shifting wins
        end else begin : g_end
            assign nv[i] = res[i];
            assign nd[i] = acc[i].data;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            sv_q  <= '0;
            hit_q <= '0;
        end else if (m_ready) begin
            sv_q  <= nv;
            hit_q <= hit;
        end
    end

    always_ff @(posedge aclk) begin
        if (m_ready) begin
            for (int i = 0; i < KERNEL_W; i++) begin
                sd_q[i] <= nd[i];
            end
        end
    end

    // every result is a single-word packet
    assign m_valid = sv_q[0];
    assign m_last  = sv_q[0];
    assign m_data  = sd_q[0];

endmodule

`default_nettype wire

// File: source/snake_control.sv
// hand-over selects and clock enables; relies on CIN >= 4 so hand-overs never overlap a lane-0 sum
`default_nettype none

module snake_control import conv_pkg::*; (
    input  logic       aclk,
    input  logic       rst,
    input  logic       m_ready,       // unit-wide enable
    input  lane_mask_t mul_last,
    input  lane_mask_t mul_valid,
    input  lane_mask_t mul_is_1x1,
    conv_acc_if.sink   acc [KERNEL_W],
    output lane_mask_t mux_sel,
    output logic       clken_mul,
    output lane_mask_t clken_acc
);

    logic [KERNEL_W-1:1] sel_q;      // lane 0 never takes a carry
    logic [KERNEL_W-1:1] sel_load;   // select register enable
    logic [KERNEL_W-1:1] sel_next;
    logic                sel_none;

    assign sel_none     = ~|sel_q;
    assign mux_sel      = {sel_q, 1'b0};
    assign clken_mul    = m_ready & sel_none; // any hand-over freezes all multipliers
    assign clken_acc[0] = clken_mul;

    for (genvar i = 1; i < KERNEL_W; i++) begin : g_sel
        logic src_valid;

        // while selected, wait for the left sum; otherwise watch own multiplier
        assign src_valid = sel_q[i] ? (acc[i-1].valid & acc[i-1].last) : mul_valid[i];

        // only the lane taking the carry keeps running during a hand-over
        assign clken_acc[i] = m_ready & (sel_none | sel_q[i]);

        // update only when this lane's accumulator moves, so a frozen last is not seen early
        assign sel_load[i] = clken_acc[i] & src_valid;
        assign sel_next[i] = mul_last[i] & ~mul_is_1x1[i]; // no snaking in 1x1
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            sel_q <= '0;
        end else begin
            for (int i = 1; i < KERNEL_W; i++) begin
                if (sel_load[i]) begin
                    sel_q[i] <= sel_next[i]; // rises on last, falls once carry taken
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/step_buffer.sv
// skews each beat so lane i lags 1+i*STEP enabled clocks; bubbles shift along with the data
`default_nettype none

module step_buffer import conv_pkg::*; (
    input  logic       aclk,
    input  logic       rst,
    input  logic       en,          // multiplier enable, freezes with them
    input  logic       in_valid,
    input  logic       in_last,
    input  logic       in_is_1x1,
    input  pix_t       in_pixels   [KERNEL_W],
    input  pix_t       in_weights  [KERNEL_W],
    output lane_mask_t lane_valid,
    output lane_mask_t lane_last,
    output lane_mask_t lane_is_1x1,
    output pix_t       lane_pixel  [KERNEL_W],
    output pix_t       lane_weight [KERNEL_W]
);

    for (genvar i = 0; i < KERNEL_W; i++) begin : g_lane
        localparam int DEPTH = 1 + i * STEP;

        logic [DEPTH-1:0] v_q, l_q, o_q; // control taps, oldest at the top
        pix_t px_q [DEPTH];
        pix_t wt_q [DEPTH];

        always_ff @(posedge aclk) begin
            if (rst) begin
                v_q <= '0;
                l_q <= '0;
                o_q <= '0;
            end else if (en) begin
                for (int k = DEPTH - 1; k > 0; k--) begin
                    v_q[k] <= v_q[k-1];
                    l_q[k] <= l_q[k-1];
                    o_q[k] <= o_q[k-1];
                end
                v_q[0] <= in_valid;
                l_q[0] <= in_last & in_valid; // last only counts on a real beat
                o_q[0] <= in_is_1x1;
            end
        end

        always_ff @(posedge aclk) begin
            if (en) begin
                for (int k = DEPTH - 1; k > 0; k--) begin
                    px_q[k] <= px_q[k-1];
                    wt_q[k] <= wt_q[k-1];
                end
                px_q[0] <= in_pixels[i];
                wt_q[0] <= in_weights[i];
            end
        end

        assign lane_valid[i]  = v_q[DEPTH-1];
        assign lane_last[i]   = l_q[DEPTH-1];
        assign lane_is_1x1[i] = o_q[DEPTH-1];
        assign lane_pixel[i]  = px_q[DEPTH-1];
        assign lane_weight[i] = wt_q[DEPTH-1];
    end

endmodule

`default_nettype wire

// File: tb/conv_unit_assertions.sv
// bound into conv_unit by port name; covers only top-level port rules, hits are tallied in fail_count
`default_nettype none

module conv_unit_assertions import conv_pkg::*; (
    input logic aclk,
    input logic rst,
    input logic s_ready,
    input logic m_ready,
    input logic m_valid,
    input sum_t m_data
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // stalled output keeps its word; data is only defined while valid
    valid_holds: assert property (@(posedge aclk) disable iff (rst) !m_ready |=> $stable(m_valid))
        else begin
            $error("m_valid changed during a stall");
            fail_count++;
        end

    data_holds: assert property (@(posedge aclk) disable iff (rst)
        !m_ready && m_valid |=> $stable(m_data))
        else begin
            $error("m_data changed during a stall");
            fail_count++;
        end

    no_ready_in_stall: assert property (@(posedge aclk) disable iff (rst) !m_ready |-> !s_ready)
        else begin
            $error("s_ready high while m_ready low");
            fail_count++;
        end

endmodule

bind conv_unit conv_unit_assertions i_checks (.*);

`default_nettype wire

// File: tb/conv_unit_tb.sv
// random runs with zero-weight flush; 1x1 groups need 6 or more beats or the shift chain drops or reorders words
`default_nettype none

module conv_unit_tb import conv_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RUNS        = 12;
    localparam int FLUSH       = KERNEL_W - 1; // zero groups that empty the carry chain
    localparam int BEAT_LIMIT  = 200;          // clocks allowed per input beat
    localparam int DRAIN_LIMIT = 2000;         // clocks allowed for a run's results

    logic aclk;
    logic rst;
    logic s_valid;
    logic s_last;
    logic s_is_1x1;
    logic s_ready;
    logic m_ready;
    logic m_valid;
    logic m_last;
    pix_t s_pixels  [KERNEL_W];
    pix_t s_weights [KERNEL_W];
    sum_t m_data;

    integer seed = 32'hec7c;
    int     drops = 0;                    // enabled clocks with s_ready low
    sum_t   exp_q [$];                    // expected words, set after set
    int     set_q [$];                    // words per set
    sum_t   got_q [$];                    // words of the set being collected
    sum_t   hist  [KERNEL_W-1][KERNEL_W]; // lane sums of earlier groups, newest first

    conv_unit i_dut (
        .aclk(aclk), .rst(rst), .s_valid(s_valid), .s_last(s_last), .s_is_1x1(s_is_1x1),
        .s_pixels(s_pixels), .s_weights(s_weights), .s_ready(s_ready),
        .m_ready(m_ready), .m_valid(m_valid), .m_last(m_last), .m_data(m_data)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [SUM_W-1:0] got,
                               input logic [SUM_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    // one clock, then new inputs just after the edge
    task automatic step_clock();
        @(posedge aclk);
        #1;
        m_ready = ($unsigned($random(seed)) % 5) != 0; // low about one clock in five
    endtask

    task automatic send_group(input int cin, input logic mode, input logic flush);
        sum_t s [KERNEL_W];
        sum_t total;
        int   prod;
        int   waited;
        logic taken;
        for (int k = 0; k < KERNEL_W; k++) begin
            s[k] = '0;
        end
        for (int b = 0; b < cin; b++) begin
            for (int k = 0; k < KERNEL_W; k++) begin
                s_pixels[k]  = pix_t'($random(seed));
                s_weights[k] = flush ? pix_t'(0) : pix_t'($random(seed));
                prod = int'(s_pixels[k]) * int'(s_weights[k]);
                s[k] = s[k] + sum_t'(prod); // wraps at SUM_W bits
            end
            s_valid  = 1'b1;
            s_last   = (b == cin - 1);
            s_is_1x1 = mode;
            waited   = 0;
            taken    = 1'b0;
            while (!taken) begin
                @(negedge aclk);
                taken = s_ready && m_ready;
                step_clock();
                waited++;
                if (!taken && waited > BEAT_LIMIT) begin
                    abort_run("input beat not accepted before the timeout");
                end
            end
        end
        if (mode) begin
            for (int k = 0; k < KERNEL_W; k++) begin
                exp_q.push_back(s[k]); // each lane closes its own group
            end
            set_q.push_back(KERNEL_W);
        end else begin
            total = s[KERNEL_W-1];
            for (int k = 0; k < KERNEL_W - 1; k++) begin
                total = total + hist[KERNEL_W-2-k][k]; // lane k is KERNEL_W-1-k groups back
            end
            exp_q.push_back(total);
            set_q.push_back(1);
        end
        for (int d = KERNEL_W - 2; d > 0; d--) begin
            hist[d] = hist[d-1];
        end
        hist[0] = s;
    endtask

    // 1x1 sets compared without regard to order
    task automatic compare_set();
        sum_t want [$];
        int   n;
        n = set_q.pop_front();
        for (int i = 0; i < n; i++) begin
            want.push_back(exp_q.pop_front());
        end
        got_q.sort();
        want.sort();
        for (int i = 0; i < n; i++) begin
            check_value("m_data", got_q[i], want[i]);
        end
        got_q.delete();
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (set_q.size() != 0) begin
            step_clock();
            waited++;
            if (waited > DRAIN_LIMIT) begin
                abort_run("results still missing after the drain timeout");
            end
        end
    endtask

    // outputs and inputs are stable at the falling edge
    always @(negedge aclk) begin
        if (i_dut.i_checks.fail_count != 0) begin
            abort_run("a bound assertion on the DUT ports failed");
        end
        if (!rst && m_ready && !s_ready) begin
            drops++; // hand-over in progress
        end
        if (!rst && m_valid && m_ready) begin
            if (set_q.size() == 0) begin
                abort_run("DUT produced a result that no group accounts for");
            end
            check_value("m_last", m_last, 1'b1); // single-word packets
            got_q.push_back(m_data);
            if (got_q.size() == set_q[0]) begin
                compare_set();
            end
        end
    end

    initial begin
        int   groups;
        int   cin;
        logic mode;
        rst      = 1'b1;
        s_valid  = 1'b0;
        s_last   = 1'b0;
        s_is_1x1 = 1'b0;
        m_ready  = 1'b1;
        for (int k = 0; k < KERNEL_W; k++) begin
            s_pixels[k]  = '0;
            s_weights[k] = '0;
        end
        repeat (5) step_clock();
        rst = 1'b0;
        repeat (8) begin
            @(negedge aclk);
            check_value("m_valid", m_valid, 1'b0);
            check_value("s_ready", s_ready, m_ready); // no select set after reset
            step_clock();
        end
        for (int r = 0; r < RUNS; r++) begin
            mode   = (r % 2) == 1;
            groups = 2 + $unsigned($random(seed)) % 4;
            for (int d = 0; d < KERNEL_W - 1; d++) begin
                for (int k = 0; k < KERNEL_W; k++) begin
                    hist[d][k] = '0; // groups before the run count as zero
                end
            end
            for (int g = 0; g < groups + FLUSH; g++) begin
                cin = mode ? 6 + $unsigned($random(seed)) % 4 : 4 + $unsigned($random(seed)) % 6;
                send_group(cin, mode, g >= groups);
            end
            s_valid = 1'b0;
            s_last  = 1'b0;
            wait_drain();
        end
        repeat (50) step_clock(); // quiet tail, catches late duplicates
        if (drops == 0) begin
            abort_run("s_ready never dropped during a hand-over");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
source/conv_pkg.sv
source/conv_acc_if.sv
source/step_buffer.sv
source/snake_control.sv
source/conv_datapath.sv
source/output_shifter.sv
source/conv_unit.sv
tb/conv_unit_assertions.sv
tb/conv_unit_tb.sv
